// ==== sim.f ====
+incdir+tests
hw/corePkg.sv
hw/regFile.sv
hw/operandForward.sv
hw/issueStage.sv
hw/executeUnit.sv
hw/writebackStage.sv
hw/coreTop.sv
tests/coreTb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps -j 0
LINTFLAGS := --lint-only -Wall --timing
TOP       := coreTb
RTL_TOP   := coreTop
FILELIST  := sim.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
RTL_FILES := $(filter hw/%,$(shell cat $(FILELIST)))
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST))) tests/coreVectors.svh

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJDIR) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJDIR)

// ==== tests/coreVectors.svh ====
// Each row holds the instruction word, idle cycles before issue (gapRandom picks 0 to 3),
// the expected destination (0 means no writeback) and the expected value
localparam logic [2:0] gapRandom = 3'd7;
localparam int rowCount = 31;

// Rows offered while decode is held behind a MUL and its consumer
localparam int mulStallRows [2] = '{17, 19};

localparam row_t vectors [rowCount] = '{
    // Immediates with sign extension, then forwarding from execute and memory
    '{32'h24010005, 3'd0, 5'd1, 32'h00000005},
    '{32'h2402fffd, 3'd0, 5'd2, 32'hfffffffd},
    '{32'h00221821, 3'd0, 5'd3, 32'h00000002},
    '{32'h00612023, 3'd0, 5'd4, 32'hfffffffd},
    '{32'h0081282a, 3'd0, 5'd5, 32'h00000001},
    '{32'h0081302b, 3'd0, 5'd6, 32'h00000000},
    // LUI, then zero-extended logic immediates
    '{32'h3c071234, 3'd0, 5'd7, 32'h12340000},
    '{32'h34e78765, 3'd0, 5'd7, 32'h12348765},
    '{32'h30488ff0, 3'd0, 5'd8, 32'h00008ff0},
    '{32'h38e9ffff, 3'd0, 5'd9, 32'h1234789a},
    '{32'h284afffe, 3'd0, 5'd10, 32'h00000001},
    '{32'h282b8000, 3'd0, 5'd11, 32'h00000000},
    '{32'h00e86024, 3'd0, 5'd12, 32'h00008760},
    '{32'h00246825, 3'd0, 5'd13, 32'hfffffffd},
    '{32'h01a97026, 3'd0, 5'd14, 32'hedcb8767},
    // MUL results read at once by the next instruction, first as rs and then as rt
    '{32'h70227802, 3'd0, 5'd15, 32'hfffffff1},
    '{32'h01e18021, 3'd0, 5'd16, 32'hfffffff6},
    '{32'h72108802, 3'd0, 5'd17, 32'h00000064},
    '{32'h70f19002, 3'd0, 5'd18, 32'h1c84e374},
    // Write to r0, unsupported ADD, unknown opcode
    '{32'h00210021, 3'd0, 5'd0, 32'h00000000},
    '{32'h00221820, 3'd0, 5'd0, 32'h00000000},
    '{32'hfc000000, 3'd0, 5'd0, 32'h00000000},
    '{32'h00039821, 3'd0, 5'd19, 32'h00000002},
    '{32'h24147fff, 3'd2, 5'd20, 32'h00007fff},
    // Random issue gaps
    '{32'h0249a821, gapRandom, 5'd21, 32'h2eb95c0e},
    '{32'h72a1b002, gapRandom, 5'd22, 32'he99ecc46},
    '{32'h02cfb823, gapRandom, 5'd23, 32'he99ecc55},
    '{32'h02e0c02a, gapRandom, 5'd24, 32'h00000001},
    '{32'h3af900ff, gapRandom, 5'd25, 32'he99eccaa},
    '{32'h03390021, gapRandom, 5'd0, 32'h00000000},
    '{32'h0338d021, 3'd0, 5'd26, 32'he99eccab}
};

// ==== tests/coreTb.sv ====
module coreTb import corePkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        word_t      instr;
        logic [2:0] gap;
        regAddr_t   dest;
        word_t      value;
    } row_t;

    `include "coreVectors.svh"

    logic clk = 1'b0;
    logic reset;
    logic instrValid;
    word_t instr;
    logic instrReady;
    wbInfo_t wb;

    int errorCount = 0;
    int wbSeen = 0;
    int expectedWb = 0;
    int monitorIdx = 0;
    int waitCycles [rowCount];
    logic [31:0] rngState = 32'h2a92_70d2;

    coreTop dut0 (
        .clk(clk),
        .reset(reset),
        .instrValid(instrValid),
        .instr(instr),
        .instrReady(instrReady),
        .wb(wb)
    );

    always #5 clk = ~clk;

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            errorCount++;
            $display("ERROR %s: got %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    function automatic logic [31:0] nextRandom(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Starts and ends 1 ns after a rising edge
    task automatic issueRow(input int idx);
        int gap;
        logic ready;
        gap = int'(vectors[idx].gap);
        if (vectors[idx].gap == gapRandom) begin
            rngState = nextRandom(rngState);
            gap = int'(rngState[1:0]);
        end
        if (gap > 0) begin
            instrValid = 1'b0;
            repeat (gap) @(posedge clk);
            #1;
        end
        instrValid = 1'b1;
        instr = vectors[idx].instr;
        ready = 1'b0;
        while (!ready) begin
            @(negedge clk);
            ready = instrReady;
            if (!ready) begin
                waitCycles[idx]++;
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic printSummary();
        $display("Summary: %0d of %0d writebacks seen, %0d errors",
                 wbSeen, expectedWb, errorCount);
    endtask

    // Writebacks must come in table order, skipping rows without a destination
    always @(negedge clk) begin
        if (!reset && wb.wen != '0) begin
            while (monitorIdx < rowCount && vectors[monitorIdx].dest == '0) begin
                monitorIdx++;
            end
            if (monitorIdx == rowCount) begin
                errorCount++;
                $display("Writeback to register %0d with pc %h is not in the table",
                         wb.num, wb.pc);
            end else begin
                check("wb.wen", 32'(wb.wen), 32'hf);
                check("wb.num", 32'(wb.num), 32'(vectors[monitorIdx].dest));
                check("wb.data", wb.data, vectors[monitorIdx].value);
                check("wb.pc", wb.pc, pcStep * word_t'(monitorIdx));
                monitorIdx++;
                wbSeen++;
            end
        end
    end

    initial begin
        reset = 1'b1;
        instrValid = 1'b0;
        instr = '0;
        for (int i = 0; i < rowCount; i++) begin
            if (vectors[i].dest != '0) begin
                expectedWb++;
            end
        end
        // Idle outputs while held in reset
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            if (i < 15) begin
                @(negedge clk);
                check("wb.wen", 32'(wb.wen), 32'h0);
                check("instrReady", 32'(instrReady), 32'h1);
            end
        end
        #1;
        reset = 1'b0;
        for (int i = 0; i < rowCount; i++) begin
            issueRow(i);
        end
        instrValid = 1'b0;
        instr = '0;
        wait (wbSeen == expectedWb);
        // Room for a stray writeback after the last row
        repeat (8) @(posedge clk);
        for (int i = 0; i < rowCount; i++) begin
            if (vectors[i].gap != gapRandom) begin
                check("instrReady low cycles", 32'(waitCycles[i]),
                      (i == mulStallRows[0] || i == mulStallRows[1]) ? 32'd1 : 32'd0);
            end
        end
        printSummary();
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        repeat (16 + rowCount * 8 + 40) @(posedge clk);
        $display("Timeout: writebacks are missing, only %0d of %0d arrived",
                 wbSeen, expectedWb);
        printSummary();
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== hw/coreTop.sv ====
module coreTop (
    input  logic             clk,
    input  logic             reset,
    input  logic             instrValid,
    input  corePkg::word_t   instr,
    output logic             instrReady,
    output corePkg::wbInfo_t wb
);

    corePkg::ctrl_t decCtrl;
    corePkg::word_t decPc;
    logic decValid;
    logic useA;
    logic useB;
    logic hazardA;
    logic hazardB;

    corePkg::word_t readDataA;
    corePkg::word_t readDataB;
    corePkg::word_t operandA;
    corePkg::word_t operandB;

    corePkg::ctrl_t execCtrl;
    corePkg::word_t execA;
    corePkg::word_t execB;
    corePkg::word_t execResult;
    corePkg::word_t execPc;
    logic execValid;

    corePkg::fwdSrc_t execFwd;
    corePkg::fwdSrc_t memFwd;
    corePkg::regAddr_t regWriteAddr;
    corePkg::word_t regWriteData;

    issueStage issue0 (
        .clk(clk),
        .reset(reset),
        .instrValid(instrValid),
        .instr(instr),
        .instrReady(instrReady),
        .hazardA(hazardA),
        .hazardB(hazardB),
        .ctrl(decCtrl),
        .pc(decPc),
        .valid(decValid),
        .useA(useA),
        .useB(useB)
    );

    regFile regs0 (
        .clk(clk),
        .reset(reset),
        .readAddrA(decCtrl.srcA),
        .readAddrB(decCtrl.srcB),
        .readDataA(readDataA),
        .readDataB(readDataB),
        .writeAddr(regWriteAddr),
        .writeData(regWriteData)
    );

    // One forwarding unit per source operand
    operandForward fwdA (
        .request(decCtrl.srcA),
        .enable(useA),
        .original(readDataA),
        .srcExec(execFwd),
        .srcMem(memFwd),
        .value(operandA),
        .hazard(hazardA)
    );

    operandForward fwdB (
        .request(decCtrl.srcB),
        .enable(useB),
        .original(readDataB),
        .srcExec(execFwd),
        .srcMem(memFwd),
        .value(operandB),
        .hazard(hazardB)
    );

    // Decode holds exactly when it refuses new instructions
    executeUnit exec0 (
        .clk(clk),
        .reset(reset),
        .ctrl(decCtrl),
        .pc(decPc),
        .valid(decValid),
        .stall(!instrReady),
        .operandA(operandA),
        .operandB(operandB),
        .execCtrl(execCtrl),
        .execA(execA),
        .execB(execB),
        .execResult(execResult),
        .execPc(execPc),
        .execValid(execValid),
        .execFwd(execFwd)
    );

    writebackStage wback0 (
        .clk(clk),
        .reset(reset),
        .execCtrl(execCtrl),
        .execA(execA),
        .execB(execB),
        .execResult(execResult),
        .execPc(execPc),
        .execValid(execValid),
        .memFwd(memFwd),
        .regWriteAddr(regWriteAddr),
        .regWriteData(regWriteData),
        .wb(wb)
    );

endmodule

// ==== hw/writebackStage.sv ====
module writebackStage import corePkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  ctrl_t    execCtrl,
    input  word_t    execA,
    input  word_t    execB,
    input  word_t    execResult,
    input  word_t    execPc,
    input  logic     execValid,
    output fwdSrc_t  memFwd,
    output regAddr_t regWriteAddr,
    output word_t    regWriteData,
    output wbInfo_t  wb
);

    word_t product;
    word_t memData;
    word_t memPc;
    regAddr_t memDest;
    logic memValid;

    // Low half only
    assign product = execA * execB;

    always_ff @(posedge clk) begin
        if (reset) begin
            memValid <= 1'b0;
        end else begin
            memValid <= execValid;
        end
    end

    always_ff @(posedge clk) begin
        memData <= execCtrl.isMul ? product : execResult;
        memDest <= execCtrl.dest;
        memPc <= execPc;
    end

    assign regWriteAddr = memValid ? memDest : '0;
    assign regWriteData = memData;

    assign memFwd.valid = (regWriteAddr != '0);
    assign memFwd.dest = regWriteAddr;
    assign memFwd.value = memData;

    assign wb.wen = (regWriteAddr != '0) ? 4'hf : 4'h0;
    assign wb.pc = memPc;
    assign wb.num = regWriteAddr;
    assign wb.data = memData;

endmodule

// ==== hw/executeUnit.sv ====
module executeUnit import corePkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  ctrl_t   ctrl,
    input  word_t   pc,
    input  logic    valid,
    input  logic    stall,
    input  word_t   operandA,
    input  word_t   operandB,
    output ctrl_t   execCtrl,
    output word_t   execA,
    output word_t   execB,
    output word_t   execResult,
    output word_t   execPc,
    output logic    execValid,
    output fwdSrc_t execFwd
);

    word_t opB;
    word_t aluOut;
    regAddr_t execDest;

    assign opB = ctrl.useImm ? ctrl.imm : operandB;

    always_comb begin
        case (ctrl.aluOp)
            aluAdd:  aluOut = operandA + opB;
            aluSub:  aluOut = operandA - opB;
            aluAnd:  aluOut = operandA & opB;
            aluOr:   aluOut = operandA | opB;
            aluXor:  aluOut = operandA ^ opB;
            aluSlt:  aluOut = word_t'($signed(operandA) < $signed(opB));
            aluSltu: aluOut = word_t'(operandA < opB);
            aluLui:  aluOut = opB;
            // Product is formed in the next stage
            default: aluOut = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            execValid <= 1'b0;
        end else begin
            execValid <= valid && !stall;
        end
    end

    always_ff @(posedge clk) begin
        execCtrl <= ctrl;
        execA <= operandA;
        execB <= opB;
        execResult <= aluOut;
        execPc <= pc;
    end

    // A bubble must never match a waiting operand
    assign execDest = execValid ? execCtrl.dest : '0;

    assign execFwd.valid = (execDest != '0) && !execCtrl.isMul;
    assign execFwd.dest = execDest;
    assign execFwd.value = execResult;

endmodule

// ==== hw/issueStage.sv ====
module issueStage import corePkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  instrValid,
    input  word_t instr,
    output logic  instrReady,
    input  logic  hazardA,
    input  logic  hazardB,
    output ctrl_t ctrl,
    output word_t pc,
    output logic  valid,
    output logic  useA,
    output logic  useB
);

    logic [5:0] opcode;
    logic [5:0] funct;
    regAddr_t rs;
    regAddr_t rt;
    regAddr_t rd;
    logic [15:0] imm16;

    logic known;
    logic rType;
    logic zeroExt;
    logic isMul;
    aluOp_t aluOp;
    ctrl_t decoded;

    word_t pcCount;
    logic hold;
    logic accept;

    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign funct  = instr[5:0];
    assign imm16  = instr[15:0];

    always_comb begin
        known = 1'b1;
        rType = 1'b1;
        zeroExt = 1'b0;
        isMul = 1'b0;
        aluOp = aluAdd;
        case (opcode)
            opSpecial: begin
                case (funct)
                    fnAddu: aluOp = aluAdd;
                    fnSubu: aluOp = aluSub;
                    fnAnd:  aluOp = aluAnd;
                    fnOr:   aluOp = aluOr;
                    fnXor:  aluOp = aluXor;
                    fnSlt:  aluOp = aluSlt;
                    fnSltu: aluOp = aluSltu;
                    default: known = 1'b0;
                endcase
            end
            opSpecial2: begin
                aluOp = aluMul;
                isMul = 1'b1;
                known = (funct == fnMul);
            end
            opAddiu: rType = 1'b0;
            opSlti: begin
                rType = 1'b0;
                aluOp = aluSlt;
            end
            opAndi: begin
                rType = 1'b0;
                zeroExt = 1'b1;
                aluOp = aluAnd;
            end
            opOri: begin
                rType = 1'b0;
                zeroExt = 1'b1;
                aluOp = aluOr;
            end
            opXori: begin
                rType = 1'b0;
                zeroExt = 1'b1;
                aluOp = aluXor;
            end
            opLui: begin
                rType = 1'b0;
                aluOp = aluLui;
            end
            default: known = 1'b0;
        endcase

        decoded.aluOp = aluOp;
        decoded.srcA = rs;
        decoded.srcB = rType ? rt : '0;
        decoded.useImm = !rType;
        decoded.zeroExtImm = zeroExt;
        if (aluOp == aluLui) begin
            decoded.imm = {imm16, 16'h0000};
        end else if (zeroExt) begin
            decoded.imm = {16'h0000, imm16};
        end else begin
            decoded.imm = {{16{imm16[15]}}, imm16};
        end
        decoded.dest = rType ? rd : rt;
        decoded.isMul = isMul;
        // Unknown opcodes turn into a no-op writing nothing
        if (!known) begin
            decoded = '0;
        end
    end

    assign hold = valid && (hazardA || hazardB);
    assign instrReady = !hold;
    assign accept = instrValid && instrReady;

    // LUI ignores rs, immediate forms ignore rt
    assign useA = valid && (ctrl.aluOp != aluLui);
    assign useB = valid && !ctrl.useImm;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
            pcCount <= '0;
        end else if (!hold) begin
            valid <= accept;
            if (accept) begin
                pcCount <= pcCount + pcStep;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ctrl <= decoded;
            pc <= pcCount;
        end
    end

endmodule

// ==== hw/operandForward.sv ====
module operandForward import corePkg::*; (
    input  regAddr_t request,
    input  logic     enable,
    input  word_t    original,
    input  fwdSrc_t  srcExec,
    input  fwdSrc_t  srcMem,
    output word_t    value,
    output logic     hazard
);

    logic matchExec;
    logic matchMem;

    assign matchExec = (srcExec.dest == request);
    assign matchMem = srcMem.valid && (srcMem.dest == request);

    always_comb begin
        value = original;
        hazard = 1'b0;
        if (!enable || request == '0) begin
            value = '0;
        end else if (matchExec) begin
            // Youngest writer wins, even if its value is not ready yet
            if (srcExec.valid) begin
                value = srcExec.value;
            end else begin
                hazard = 1'b1;
            end
        end else if (matchMem) begin
            value = srcMem.value;
        end
    end

endmodule

// ==== hw/regFile.sv ====
module regFile import corePkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  regAddr_t readAddrA,
    input  regAddr_t readAddrB,
    output word_t    readDataA,
    output word_t    readDataB,
    input  regAddr_t writeAddr,
    input  word_t    writeData
);

    word_t regs [regCount];

    // Register 0 is never written, so it keeps its reset value of zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

endmodule

// ==== hw/corePkg.sv ====
package corePkg;

    localparam int wordWidth = 32;
    localparam int regCount = 32;
    localparam int regAddrWidth = 5;

    typedef logic [wordWidth-1:0] word_t;
    typedef logic [regAddrWidth-1:0] regAddr_t;

    localparam word_t pcStep = 32'd4;

    // Opcode field values
    localparam logic [5:0] opSpecial  = 6'h00;
    localparam logic [5:0] opSpecial2 = 6'h1c;
    localparam logic [5:0] opAddiu    = 6'h09;
    localparam logic [5:0] opSlti     = 6'h0a;
    localparam logic [5:0] opAndi     = 6'h0c;
    localparam logic [5:0] opOri      = 6'h0d;
    localparam logic [5:0] opXori     = 6'h0e;
    localparam logic [5:0] opLui      = 6'h0f;

    // Function field values
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnSlt  = 6'h2a;
    localparam logic [5:0] fnSltu = 6'h2b;
    // MUL lives under SPECIAL2
    localparam logic [5:0] fnMul  = 6'h02;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSltu,
        aluLui,
        aluMul
    } aluOp_t;

    typedef struct packed {
        aluOp_t   aluOp;
        regAddr_t srcA;
        regAddr_t srcB;
        logic     useImm;
        logic     zeroExtImm;
        word_t    imm;
        regAddr_t dest;
        logic     isMul;
    } ctrl_t;

    // Register value in flight
    typedef struct packed {
        logic     valid;
        regAddr_t dest;
        word_t    value;
    } fwdSrc_t;

    typedef struct packed {
        logic [3:0] wen;
        word_t      pc;
        regAddr_t   num;
        word_t      data;
    } wbInfo_t;

endpackage
